/* src/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B    // LUI
    } alu_op_t;

    // Address bits 31:29 select the target of a load or store
    localparam logic [2:0] REGION_RAM  = 3'd0;
    localparam logic [2:0] REGION_PWM  = 3'd1;
    localparam logic [2:0] REGION_GPIO = 3'd2;

    localparam logic [7:0] PWM_PERIOD_OFS = 8'h00;
    localparam logic [7:0] PWM_DUTY_OFS   = 8'h04;

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

/* src/fetch.sv */
`timescale 1ns/1ns

module fetch (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        enable,
    input  logic        load_use_stall,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    input  logic [31:0] rom_data,
    output logic [31:0] rom_address,
    output logic [31:0] pc,
    output logic [31:0] instr
);
    logic [31:0] fetch_pc;

    assign rom_address = fetch_pc;    // ROM answers in the same cycle

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fetch_pc <= '0;
            pc       <= '0;
            instr    <= cpu_pkg::NOP_INSTR;
        end else if (enable) begin
            if (branch_taken) begin
                // Redirect and drop the wrong-path fetch
                fetch_pc <= branch_target;
                pc       <= '0;
                instr    <= cpu_pkg::NOP_INSTR;
            end else if (!load_use_stall) begin
                fetch_pc <= fetch_pc + 32'd4;
                pc       <= fetch_pc;
                instr    <= rom_data;
            end
        end
    end

endmodule

/* src/decode.sv */
`timescale 1ns/1ns

module decode (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enable,
    input  logic             branch_taken,
    input  logic [31:0]      next_instruction,
    input  logic [31:0]      pc_in,
    input  logic [31:0]      regbank_value1,
    input  logic [31:0]      regbank_value2,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic             load_use_stall,
    output logic [31:0]      pc_out,
    output logic [31:0]      value1,
    output logic [31:0]      value2,
    output logic [31:0]      imm,
    output logic [4:0]       rs1_out,
    output logic [4:0]       rs2_out,
    output logic [4:0]       reg_dest,
    output cpu_pkg::alu_op_t alu_op,
    output logic             alu_src,
    output logic             branch,
    output logic             mem_read,
    output logic             mem_write,
    output logic             reg_write,
    output logic             mem_to_reg
);
    logic [31:0]      instr;
    logic [4:0]       rd;
    logic [31:0]      d_imm;
    cpu_pkg::alu_op_t d_alu_op;
    logic             d_alu_src, d_branch, d_mem_read, d_mem_write, d_reg_write;
    logic             use_rs1, use_rs2;

    assign instr = next_instruction;
    assign rd    = instr[11:7];
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];

    always_comb begin
        d_imm       = '0;
        d_alu_op    = cpu_pkg::ALU_ADD;
        d_alu_src   = 1'b0;
        d_branch    = 1'b0;
        d_mem_read  = 1'b0;
        d_mem_write = 1'b0;
        d_reg_write = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (instr[6:0])
            cpu_pkg::OPC_OP: begin
                d_reg_write = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                case ({instr[31:25], instr[14:12]})
                    10'b0000000_000: d_alu_op = cpu_pkg::ALU_ADD;
                    10'b0100000_000: d_alu_op = cpu_pkg::ALU_SUB;
                    10'b0000000_111: d_alu_op = cpu_pkg::ALU_AND;
                    10'b0000000_110: d_alu_op = cpu_pkg::ALU_OR;
                    10'b0000000_100: d_alu_op = cpu_pkg::ALU_XOR;
                    default: begin    // Other R-type ops become NOPs
                        d_reg_write = 1'b0;
                        use_rs1     = 1'b0;
                        use_rs2     = 1'b0;
                    end
                endcase
            end
            cpu_pkg::OPC_OP_IMM: if (instr[14:12] == 3'b000) begin    // ADDI only
                d_imm       = {{20{instr[31]}}, instr[31:20]};
                d_alu_src   = 1'b1;
                d_reg_write = 1'b1;
                use_rs1     = 1'b1;
            end
            cpu_pkg::OPC_LUI: begin
                d_imm       = {instr[31:12], 12'b0};
                d_alu_op    = cpu_pkg::ALU_PASS_B;
                d_alu_src   = 1'b1;
                d_reg_write = 1'b1;
            end
            cpu_pkg::OPC_LOAD: if (instr[14:12] == 3'b010) begin      // LW
                d_imm       = {{20{instr[31]}}, instr[31:20]};
                d_alu_src   = 1'b1;
                d_mem_read  = 1'b1;
                d_reg_write = 1'b1;
                use_rs1     = 1'b1;
            end
            cpu_pkg::OPC_STORE: if (instr[14:12] == 3'b010) begin     // SW
                d_imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                d_alu_src   = 1'b1;
                d_mem_write = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            cpu_pkg::OPC_BRANCH: if (instr[14:12] == 3'b000) begin    // BEQ
                d_imm    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                d_branch = 1'b1;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            default: ;
        endcase
    end

    // Load in execute whose result the decoded instruction needs
    assign load_use_stall = mem_read && reg_dest != 5'd0
                            && ((use_rs1 && rs1 == reg_dest) || (use_rs2 && rs2 == reg_dest));

    always_ff @(posedge clock) begin
        if (!rst_n || (enable && (branch_taken || load_use_stall))) begin
            alu_op     <= cpu_pkg::ALU_ADD;    // Bubble
            alu_src    <= 1'b0;
            branch     <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            reg_write  <= 1'b0;
            mem_to_reg <= 1'b0;
            reg_dest   <= '0;
            rs1_out    <= '0;
            rs2_out    <= '0;
        end else if (enable) begin
            alu_op     <= d_alu_op;
            alu_src    <= d_alu_src;
            branch     <= d_branch;
            mem_read   <= d_mem_read;
            mem_write  <= d_mem_write;
            reg_write  <= d_reg_write && rd != 5'd0;
            mem_to_reg <= d_mem_read;
            reg_dest   <= rd;
            rs1_out    <= rs1;
            rs2_out    <= rs2;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            pc_out <= pc_in;
            value1 <= regbank_value1;
            value2 <= regbank_value2;
            imm    <= d_imm;
        end
    end

endmodule

/* src/execute.sv */
`timescale 1ns/1ns

module execute (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enable,
    input  logic [31:0]      pc,
    input  logic [31:0]      value1,
    input  logic [31:0]      value2,
    input  logic [31:0]      imm,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       reg_dest,
    input  cpu_pkg::alu_op_t alu_op,
    input  logic             alu_src,
    input  logic             branch,
    input  logic             mem_read,
    input  logic             mem_write,
    input  logic             reg_write,
    input  logic             mem_to_reg,
    input  logic             mem_wb_reg_write,
    input  logic [4:0]       mem_wb_rd,
    input  logic [31:0]      mem_wb_value,
    output logic             branch_taken,
    output logic [31:0]      branch_target,
    output logic [31:0]      result,
    output logic [31:0]      rs2_value,
    output logic             out_mem_read,
    output logic             out_mem_write,
    output logic             out_reg_write,
    output logic             out_mem_to_reg,
    output logic [4:0]       out_reg_dest
);
    logic [31:0] op1, op2, op_b, alu_out;

    // Newest producer first, x0 never forwarded
    function automatic logic [31:0] fwd_select(input logic [4:0] src, input logic [31:0] rf_val);
        logic [31:0] v;
        v = rf_val;
        if (mem_wb_reg_write && mem_wb_rd != 5'd0 && mem_wb_rd == src)
            v = mem_wb_value;
        if (out_reg_write && out_reg_dest != 5'd0 && out_reg_dest == src)
            v = result;    // Never a load here, the stall sees to that
        return v;
    endfunction

    always_comb begin
        op1  = fwd_select(rs1, value1);
        op2  = fwd_select(rs2, value2);
        op_b = alu_src ? imm : op2;
        case (alu_op)
            cpu_pkg::ALU_ADD: alu_out = op1 + op_b;
            cpu_pkg::ALU_SUB: alu_out = op1 - op_b;
            cpu_pkg::ALU_AND: alu_out = op1 & op_b;
            cpu_pkg::ALU_OR:  alu_out = op1 | op_b;
            cpu_pkg::ALU_XOR: alu_out = op1 ^ op_b;
            default:          alu_out = op_b;
        endcase
    end

    // Resolved here, fetch redirects on the next edge
    assign branch_taken  = branch && (op1 == op2);
    assign branch_target = pc + imm;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_mem_read   <= 1'b0;
            out_mem_write  <= 1'b0;
            out_reg_write  <= 1'b0;
            out_mem_to_reg <= 1'b0;
            out_reg_dest   <= '0;
        end else if (enable) begin
            out_mem_read   <= mem_read;
            out_mem_write  <= mem_write;
            out_reg_write  <= reg_write;
            out_mem_to_reg <= mem_to_reg;
            out_reg_dest   <= reg_dest;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            result    <= alu_out;    // Address for loads and stores
            rs2_value <= op2;
        end
    end

endmodule

/* src/memory.sv */
`timescale 1ns/1ns

module memory (
    input  logic [cpu_pkg::XLEN-1:0] result,
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     enable,
    input  logic [cpu_pkg::XLEN-1:0] rs2_value,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  logic                     reg_write,
    input  logic                     mem_to_reg,
    input  logic [4:0]               reg_dest,
    input  logic [cpu_pkg::XLEN-1:0] mem_read_data,
    output logic [cpu_pkg::XLEN-1:0] mem_addr,
    output logic [cpu_pkg::XLEN-1:0] mem_write_data,
    output logic                     mem_write_enable,
    output logic                     mem_read_enable,
    output logic                     rb_write_enable,
    output logic [4:0]               rb_write_address,
    output logic [cpu_pkg::XLEN-1:0] rb_write_value
);
    logic [cpu_pkg::XLEN-1:0] load_data;
    logic                     wb_reg_write;

    assign mem_addr         = result;
    assign mem_write_data   = rs2_value;
    assign mem_write_enable = mem_write && enable;    // Bus frozen with the pipeline
    assign mem_read_enable  = mem_read && enable;

    // Peripheral registers read back as zero
    assign load_data = (mem_read_enable && mem_addr[31:29] == cpu_pkg::REGION_RAM)
                       ? mem_read_data : '0;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_reg_write     <= 1'b0;
            rb_write_address <= '0;
        end else if (enable) begin
            wb_reg_write     <= reg_write;
            rb_write_address <= reg_dest;
        end
    end

    always_ff @(posedge clock) begin
        if (enable)
            rb_write_value <= mem_to_reg ? load_data : result;
    end

    assign rb_write_enable = wb_reg_write && enable;

endmodule

/* src/register_bank.sv */
`timescale 1ns/1ns

module register_bank (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        write_enable,
    input  logic [4:0]  write_address,
    input  logic [4:0]  read_address1,
    input  logic [4:0]  read_address2,
    input  logic [31:0] write_value,
    output logic [31:0] value1,
    output logic [31:0] value2
);
    logic [31:0] regs [32];

    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        if (write_enable && write_address == addr)
            return write_value;    // Same-cycle writeback wins
        return regs[addr];
    endfunction

    always_comb begin
        value1 = read_port(read_address1);
        value2 = read_port(read_address2);
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (write_enable && write_address != 5'd0) begin
            regs[write_address] <= write_value;
        end
    end

endmodule

/* src/ram.sv */
`timescale 1ns/1ns

module ram (
    input  logic        clock,
    input  logic        write_enable,
    input  logic [31:0] address,
    input  logic [31:0] data_in,
    output logic [31:0] data_out
);
    logic [31:0]                mem [cpu_pkg::RAM_WORDS];
    logic [cpu_pkg::RAM_AW-1:0] index;

    assign index    = address[cpu_pkg::RAM_AW+1:2];    // Word address
    assign data_out = mem[index];

    always_ff @(posedge clock) begin
        if (write_enable)
            mem[index] <= data_in;
    end

endmodule

/* src/pwm.sv */
`timescale 1ns/1ns

module pwm (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [15:0] period,
    input  logic [15:0] duty,
    output logic        out
);
    logic [15:0] count;

    // Counts 0..period, so one window is period+1 cycles
    always_ff @(posedge clock) begin
        if (!rst_n)
            count <= '0;
        else if (count >= period)
            count <= '0;    // Also catches a period lowered mid-window
        else
            count <= count + 16'd1;
    end

    assign out = count < duty;

endmodule

/* src/peripheral_manager.sv */
`timescale 1ns/1ns

module peripheral_manager (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        enable,
    input  logic [31:0] addr,
    input  logic [31:0] data_in,
    input  logic        write_enable,
    output logic [5:0]  led,
    output logic        pwm1_out
);
    logic [2:0]  region;
    logic [7:0]  offset;
    logic        wr;
    logic [15:0] pwm_period;
    logic [15:0] pwm_duty;

    assign region = addr[31:29];
    assign offset = addr[7:0];
    assign wr     = write_enable && enable;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            led        <= '0;    // GPIO register
            pwm_period <= '0;
            pwm_duty   <= '0;
        end else if (wr) begin
            if (region == cpu_pkg::REGION_GPIO)
                led <= data_in[5:0];
            if (region == cpu_pkg::REGION_PWM && offset == cpu_pkg::PWM_PERIOD_OFS)
                pwm_period <= data_in[15:0];
            if (region == cpu_pkg::REGION_PWM && offset == cpu_pkg::PWM_DUTY_OFS)
                pwm_duty <= data_in[15:0];
        end
    end

    pwm u_pwm1 (
        .clock  (clock),
        .rst_n  (rst_n),
        .period (pwm_period),
        .duty   (pwm_duty),
        .out    (pwm1_out)
    );

endmodule

/* src/cpu.sv */
`timescale 1ns/1ns

module cpu (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        enable,
    input  logic [31:0] rom_data,
    output logic [31:0] rom_address,
    output logic [5:0]  led,
    output logic        port_pwm1
);
    logic [31:0]      if_de_pc, if_de_instr;
    logic [4:0]       rb_read_address1, rb_read_address2;
    logic [31:0]      rb_value1, rb_value2;
    logic             load_use_stall;

    // ID/EX
    logic [31:0]      de_ex_pc, de_ex_value1, de_ex_value2, de_ex_imm;
    logic [4:0]       de_ex_rs1, de_ex_rs2, de_ex_reg_dest;
    cpu_pkg::alu_op_t de_ex_alu_op;
    logic             de_ex_alu_src, de_ex_branch, de_ex_mem_read, de_ex_mem_write;
    logic             de_ex_reg_write, de_ex_mem_to_reg;

    // EX/MEM and the branch redirect
    logic             branch_taken;
    logic [31:0]      branch_target;
    logic [31:0]      ex_mem_result, ex_mem_rs2_value;
    logic             ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write, ex_mem_mem_to_reg;
    logic [4:0]       ex_mem_reg_dest;

    // Writeback that doubles as the MEM/WB forwarding source
    logic             rb_write_enable;
    logic [4:0]       rb_write_address;
    logic [31:0]      rb_write_value;

    // Data bus
    logic [31:0]      mem_addr, mem_write_data, mem_read_data;
    logic             mem_write_enable, ram_write_enable;

    assign ram_write_enable = mem_write_enable && mem_addr[31:29] == cpu_pkg::REGION_RAM;

    fetch u_fetch (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .load_use_stall(load_use_stall), .branch_taken(branch_taken),
        .branch_target(branch_target), .rom_data(rom_data), .rom_address(rom_address),
        .pc(if_de_pc), .instr(if_de_instr)
    );

    decode u_decode (
        .clock(clock), .rst_n(rst_n), .enable(enable), .branch_taken(branch_taken),
        .next_instruction(if_de_instr), .pc_in(if_de_pc),
        .regbank_value1(rb_value1), .regbank_value2(rb_value2),
        .rs1(rb_read_address1), .rs2(rb_read_address2), .load_use_stall(load_use_stall),
        .pc_out(de_ex_pc), .value1(de_ex_value1), .value2(de_ex_value2), .imm(de_ex_imm),
        .rs1_out(de_ex_rs1), .rs2_out(de_ex_rs2), .reg_dest(de_ex_reg_dest),
        .alu_op(de_ex_alu_op), .alu_src(de_ex_alu_src), .branch(de_ex_branch),
        .mem_read(de_ex_mem_read), .mem_write(de_ex_mem_write),
        .reg_write(de_ex_reg_write), .mem_to_reg(de_ex_mem_to_reg)
    );

    execute u_execute (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .pc(de_ex_pc), .value1(de_ex_value1), .value2(de_ex_value2), .imm(de_ex_imm),
        .rs1(de_ex_rs1), .rs2(de_ex_rs2), .reg_dest(de_ex_reg_dest),
        .alu_op(de_ex_alu_op), .alu_src(de_ex_alu_src), .branch(de_ex_branch),
        .mem_read(de_ex_mem_read), .mem_write(de_ex_mem_write),
        .reg_write(de_ex_reg_write), .mem_to_reg(de_ex_mem_to_reg),
        .mem_wb_reg_write(rb_write_enable), .mem_wb_rd(rb_write_address),
        .mem_wb_value(rb_write_value),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .result(ex_mem_result), .rs2_value(ex_mem_rs2_value),
        .out_mem_read(ex_mem_mem_read), .out_mem_write(ex_mem_mem_write),
        .out_reg_write(ex_mem_reg_write), .out_mem_to_reg(ex_mem_mem_to_reg),
        .out_reg_dest(ex_mem_reg_dest)
    );

    memory u_memory (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .result(ex_mem_result), .rs2_value(ex_mem_rs2_value),
        .mem_read(ex_mem_mem_read), .mem_write(ex_mem_mem_write),
        .reg_write(ex_mem_reg_write), .mem_to_reg(ex_mem_mem_to_reg),
        .reg_dest(ex_mem_reg_dest), .mem_read_data(mem_read_data),
        .mem_addr(mem_addr), .mem_write_data(mem_write_data),
        .mem_write_enable(mem_write_enable), .mem_read_enable(),
        .rb_write_enable(rb_write_enable), .rb_write_address(rb_write_address),
        .rb_write_value(rb_write_value)
    );

    register_bank u_register_bank (
        .clock(clock), .rst_n(rst_n),
        .write_enable(rb_write_enable), .write_address(rb_write_address),
        .read_address1(rb_read_address1), .read_address2(rb_read_address2),
        .write_value(rb_write_value), .value1(rb_value1), .value2(rb_value2)
    );

    ram u_ram (
        .clock(clock), .write_enable(ram_write_enable), .address(mem_addr),
        .data_in(mem_write_data), .data_out(mem_read_data)
    );

    // Decodes the non-RAM regions on its own
    peripheral_manager u_peripheral_manager (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .addr(mem_addr), .data_in(mem_write_data), .write_enable(mem_write_enable),
        .led(led), .pwm1_out(port_pwm1)
    );

endmodule

/* verif/cpu_properties.sv */
`timescale 1ns/1ns

module cpu_properties (
    input logic        clock,
    input logic        rst_n,
    input logic        enable,
    input logic        rb_write_enable,
    input logic [4:0]  rb_write_address,
    input logic        branch_taken,
    input logic [31:0] if_de_instr,
    input logic        de_ex_reg_write,
    input logic        de_ex_mem_write,
    input logic        load_use_stall,
    input logic        mem_write_enable
);
    no_x0_write: assert property (@(posedge clock) disable iff (!rst_n)
        !(rb_write_enable && rb_write_address == 5'd0)) else $error("write to x0");

    // Both younger instructions dropped
    flush_after_branch: assert property (@(posedge clock) disable iff (!rst_n)
        (enable && branch_taken) |=> (if_de_instr == cpu_pkg::NOP_INSTR
                                      && !de_ex_reg_write && !de_ex_mem_write))
        else $error("no flush after taken branch");

    single_stall: assert property (@(posedge clock) disable iff (!rst_n)
        (enable && load_use_stall) |=> !load_use_stall) else $error("stall too long");

    quiet_after_reset: assert property (@(posedge clock)
        $rose(rst_n) |-> !mem_write_enable) else $error("store right after reset");

endmodule

bind cpu cpu_properties u_cpu_properties (.*);

/* verif/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;
    logic        clock;
    logic        rst_n;
    logic        enable;
    logic [31:0] rom_data;
    logic [31:0] rom_address;
    logic [5:0]  led;
    logic        port_pwm1;

    logic [31:0] rom [64];
    logic [5:0]  gpio_exp [$];
    logic [31:0] hist [$];     // rom_address on each enabled cycle
    logic [15:0] exp_period, exp_duty;
    logic [31:0] halt_pc, beq_pc, beq_target, lw_pc;
    logic [31:0] held_addr;
    logic [5:0]  held_led;
    logic        hold_valid, gpio_pending;
    integer      seed = 32'h7d89_e5ab;
    int          n, errors, checks, gpio_idx, halt_count, cycles, limit = 100000;

    cpu uut (
        .clock(clock), .rst_n(rst_n), .enable(enable), .rom_data(rom_data),
        .rom_address(rom_address), .led(led), .port_pwm1(port_pwm1)
    );

    // Asynchronous ROM that returns NOPs outside the program
    assign rom_data = (rom_address[31:8] == 24'd0) ? rom[rom_address[7:2]] : cpu_pkg::NOP_INSTR;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic emit(input logic [31:0] w);
        rom[n] = w;
        n++;
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, (opc == cpu_pkg::OPC_LOAD) ? 3'b010 : 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], cpu_pkg::OPC_BRANCH};
    endfunction

    task automatic build_program();
        logic [31:0] r;
        for (int i = 0; i < 64; i++)
            rom[i] = cpu_pkg::NOP_INSTR;
        n = 0;
        emit({20'h40000, 5'd10, cpu_pkg::OPC_LUI});    // x10 GPIO base
        emit({20'h20000, 5'd11, cpu_pkg::OPC_LUI});    // x11 PWM base
        r = $random(seed);
        emit({r[31:12], 5'd1, cpu_pkg::OPC_LUI});
        emit(enc_i(r[11:0], 5'd1, 5'd1, cpu_pkg::OPC_OP_IMM));
        r = $random(seed);
        emit({r[31:12], 5'd2, cpu_pkg::OPC_LUI});
        emit(enc_i(r[11:0], 5'd2, 5'd2, cpu_pkg::OPC_OP_IMM));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(enc_s(12'd0, 5'd3, 5'd10));
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        emit(enc_s(12'd0, 5'd4, 5'd10));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        emit(enc_s(12'd0, 5'd5, 5'd10));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd5));
        emit(enc_s(12'd0, 5'd5, 5'd10));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        emit(enc_s(12'd0, 5'd5, 5'd10));
        r = $random(seed);
        emit(enc_i(r[11:0], 5'd1, 5'd5, cpu_pkg::OPC_OP_IMM));
        emit(enc_s(12'd0, 5'd5, 5'd10));
        emit({r[31:12], 5'd6, cpu_pkg::OPC_LUI});
        emit(enc_s(12'd0, 5'd6, 5'd10));
        // Dependent chain with no gaps
        emit(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd7));
        emit(enc_r(7'h00, 5'd1, 5'd7, 3'b100, 5'd8));
        emit(enc_r(7'h00, 5'd7, 5'd8, 3'b110, 5'd9));
        emit(enc_s(12'd0, 5'd9, 5'd10));
        emit(enc_s(12'd0, 5'd8, 5'd10));
        emit(enc_s(12'd0, 5'd7, 5'd10));
        // Store, load, immediate use
        emit(enc_s(12'd16, 5'd9, 5'd0));
        lw_pc = n * 4;
        emit(enc_i(12'd16, 5'd0, 5'd12, cpu_pkg::OPC_LOAD));
        emit(enc_i(12'd5, 5'd12, 5'd13, cpu_pkg::OPC_OP_IMM));
        emit(enc_s(12'd0, 5'd13, 5'd10));
        beq_pc = n * 4;
        beq_target = beq_pc + 32'd12;
        emit(enc_b(13'd12, 5'd1, 5'd1));    // Taken and skips two
        emit(enc_i(12'd1, 5'd0, 5'd14, cpu_pkg::OPC_OP_IMM));
        emit(enc_s(12'd0, 5'd14, 5'd10));
        emit(enc_i(12'd2, 5'd0, 5'd14, cpu_pkg::OPC_OP_IMM));
        emit(enc_s(12'd0, 5'd14, 5'd10));
        emit(enc_b(13'd8, 5'd2, 5'd1));     // Not taken for distinct operands
        emit(enc_i(12'd3, 5'd0, 5'd14, cpu_pkg::OPC_OP_IMM));
        emit(enc_s(12'd0, 5'd14, 5'd10));
        r = $random(seed);
        emit(enc_i({8'd0, 1'b1, r[2:0]}, 5'd0, 5'd15, cpu_pkg::OPC_OP_IMM));
        emit(enc_s(12'd0, 5'd15, 5'd11));
        emit(enc_i({8'd0, r[7:4]}, 5'd0, 5'd16, cpu_pkg::OPC_OP_IMM));
        emit(enc_s(12'd4, 5'd16, 5'd11));
        halt_pc = n * 4;
        emit(enc_b(13'd0, 5'd0, 5'd0));     // Final loop
    endtask

    // Architectural model that runs one instruction per step
    function automatic void model_run();
        logic [31:0] x [32];
        logic [31:0] mem [256];
        logic [31:0] pc, pc_next, ins, a, b, imm_i, imm_s, imm_b, addr;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = '0;
        pc = '0;
        exp_period = '0;
        exp_duty = '0;
        gpio_exp.delete();
        for (int steps = 0; steps < 1000; steps++) begin
            ins = rom[pc[7:2]];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            pc_next = pc + 32'd4;
            case (ins[6:0])
                cpu_pkg::OPC_OP:
                    case ({ins[31:25], ins[14:12]})
                        10'h000: x[ins[11:7]] = a + b;
                        10'h100: x[ins[11:7]] = a - b;
                        10'h007: x[ins[11:7]] = a & b;
                        10'h006: x[ins[11:7]] = a | b;
                        10'h004: x[ins[11:7]] = a ^ b;
                        default: ;
                    endcase
                cpu_pkg::OPC_OP_IMM: if (ins[14:12] == 3'b000) x[ins[11:7]] = a + imm_i;
                cpu_pkg::OPC_LUI: x[ins[11:7]] = {ins[31:12], 12'b0};
                cpu_pkg::OPC_LOAD: if (ins[14:12] == 3'b010) begin
                    addr = a + imm_i;
                    x[ins[11:7]] = (addr[31:29] == cpu_pkg::REGION_RAM) ? mem[addr[9:2]] : '0;
                end
                cpu_pkg::OPC_STORE: if (ins[14:12] == 3'b010) begin
                    addr = a + imm_s;
                    if (addr[31:29] == cpu_pkg::REGION_RAM)
                        mem[addr[9:2]] = b;
                    else if (addr[31:29] == cpu_pkg::REGION_GPIO)
                        gpio_exp.push_back(b[5:0]);
                    else if (addr[31:29] == cpu_pkg::REGION_PWM && addr[7:0] == 8'h00)
                        exp_period = b[15:0];
                    else if (addr[31:29] == cpu_pkg::REGION_PWM && addr[7:0] == 8'h04)
                        exp_duty = b[15:0];
                end
                cpu_pkg::OPC_BRANCH: if (ins[14:12] == 3'b000 && a == b) begin
                    if (imm_b == '0)
                        break;
                    pc_next = pc + imm_b;
                end
                default: ;
            endcase
            x[0] = '0;
            pc = pc_next;
        end
    endfunction

    // Bus, stream and hold sampled on the rising edge and led on the falling one
    always @(posedge clock) begin
        if (rst_n) begin
            gpio_pending = uut.mem_write_enable && uut.mem_addr[31:29] == cpu_pkg::REGION_GPIO;
            if (enable) begin
                hist.push_back(rom_address);
                if (rom_address == halt_pc)
                    halt_count++;
            end else if (hold_valid) begin
                check_value("rom_address (hold)", held_addr, rom_address);
                check_value("led (hold)", {26'd0, held_led}, {26'd0, led});
            end
            held_addr = rom_address;
            held_led = led;
            hold_valid = !enable;
        end
    end

    always @(negedge clock) begin
        if (rst_n && gpio_pending) begin
            if (gpio_idx < gpio_exp.size())
                check_value("led", {26'd0, gpio_exp[gpio_idx]}, {26'd0, led});
            else begin
                errors++;
                $display("GPIO write at %0t that the program does not make", $time);
            end
            gpio_idx++;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the program did not reach its final loop");
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int idx, highs, exp_highs, start, len;
        rst_n = 1'b0;
        enable = 1'b1;
        gpio_pending = 1'b0;
        hold_valid = 1'b0;
        build_program();
        model_run();
        limit = n * 4 + 200;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
        start = 6 + ($random(seed) & 7);
        len = 2 + ($random(seed) & 7);
        repeat (start) @(negedge clock);
        enable = 1'b0;
        repeat (len) @(negedge clock);
        enable = 1'b1;
        while (halt_count < 2)
            @(negedge clock);
        // One full window to settle before counting
        repeat (int'(exp_period) + 1) @(negedge clock);
        highs = 0;
        repeat (int'(exp_period) + 1) begin
            @(negedge clock);
            if (port_pwm1)
                highs++;
        end
        exp_highs = (int'(exp_duty) < int'(exp_period) + 1) ? int'(exp_duty) : int'(exp_period) + 1;
        check_value("port_pwm1 high cycles", exp_highs, highs);
        check_value("gpio write count", gpio_exp.size(), gpio_idx);
        idx = 0;
        while (idx < hist.size() - 3 && hist[idx] != beq_pc)
            idx++;
        check_value("rom_address after BEQ", beq_target, hist[idx + 3]);
        idx = 0;
        while (idx < hist.size() - 1 && hist[idx] != lw_pc + 32'd8)
            idx++;
        check_value("rom_address in load-use stall", lw_pc + 32'd8, hist[idx + 1]);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* sim.f */
src/cpu_pkg.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/register_bank.sv
src/ram.sv
src/pwm.sv
src/peripheral_manager.sv
src/cpu.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module cpu_tb -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -qx "TEST PASS" || exit 1
exit 0
